// ==== Bender.yml ====
package:
  name: kcpu

sources:
  - common/kcpu_pkg.sv
  - source/kcpu_alu.sv
  - source/kcpu_regs.sv
  - source/kcpu_memctrl.sv
  - ctrl/kcpu_ctrl.sv
  - source/kcpu.sv
  - target: test
    files:
      - tests/kcpu_mem.sv
      - tests/kcpu_tb.sv

// ==== all.f ====
common/kcpu_pkg.sv
source/kcpu_alu.sv
source/kcpu_regs.sv
source/kcpu_memctrl.sv
ctrl/kcpu_ctrl.sv
source/kcpu.sv
tests/kcpu_mem.sv
tests/kcpu_tb.sv

// ==== common/kcpu_pkg.sv ====
// Shared types and constants for the reduced 8-bit core
// Opcodes keep the 6809 encodings, but LDA ,X takes no postbyte
// CC holds only C, V, Z and N in bits 0 to 3; upper bits stay as loaded
package kcpu_pkg;

    typedef logic [ 7:0] byte_t;   // Bus, accumulator and ALU data
    typedef logic [15:0] addr_t;   // Address, X, PC and fault address
    typedef logic [ 7:0] opcode_t;

    // Inherent
    localparam opcode_t OP_NOP      = 8'h12;
    localparam opcode_t OP_DECB     = 8'h5a;

    // Immediate
    localparam opcode_t OP_LDA_IMM  = 8'h86;
    localparam opcode_t OP_LDB_IMM  = 8'hc6;
    localparam opcode_t OP_ADDA_IMM = 8'h8b;
    localparam opcode_t OP_SUBA_IMM = 8'h80;
    localparam opcode_t OP_ANDA_IMM = 8'h84;
    localparam opcode_t OP_LDX_IMM  = 8'h8e;   // Two operand bytes

    // Extended and indexed
    localparam opcode_t OP_LDA_EXT  = 8'hb6;
    localparam opcode_t OP_STA_EXT  = 8'hb7;
    localparam opcode_t OP_LDA_IDX  = 8'ha6;   // Always ,X with no offset
    localparam opcode_t OP_JMP_EXT  = 8'h7e;

    // Relative
    localparam opcode_t OP_BNE      = 8'h26;

    // Flag positions inside CC
    localparam int CC_C = 0;
    localparam int CC_V = 1;
    localparam int CC_Z = 2;
    localparam int CC_N = 3;

    typedef enum logic [2:0] {
        ALU_PASS,   // Second operand straight through
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_DEC
    } alu_op_e;

    localparam addr_t RESET_PC = 16'h0000;

endpackage

// ==== ctrl/kcpu_ctrl.sv ====
// Fetch, decode and execute sequencer
// The opcode is decoded on the fetch enable itself, so no decode cycle is spent
// LDX does not touch CC; STA and JMP leave CC alone as well
// An undefined opcode stops the core until reset
`timescale 1ns/100ps

module kcpu_ctrl import kcpu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    cen,
    input  logic    halt,
    input  logic    mem_busy,
    input  opcode_t op,
    input  addr_t   mdata,
    input  byte_t   cc,

    // Bus requests
    output logic    fetch,
    output logic    opd,
    output logic    rd_x,
    output logic    wrq,
    output logic    hi_addr,

    // Register strobes
    output logic    up_a,
    output logic    up_b,
    output logic    up_x,
    output logic    up_pc,
    output logic    up_cc,
    output logic    pc_rel,
    output alu_op_e alu_sel,

    output logic    buserror,
    output addr_t   pcbad
);

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_OPD_HI,
        ST_OPD_LO,
        ST_DATA,
        ST_EXEC,
        ST_STOP
    } state_e;

    state_e     state, nx_state;
    logic [1:0] n_opd;                 // Operand bytes after the opcode
    logic       data_acc, store, idx, illegal;
    logic       e_a, e_b, e_x, e_pc, e_cc, rel, has_exec;
    logic       step;

    assign step = cen & ~mem_busy;

    // Opcode decode
    always_comb begin
        n_opd    = 2'd0;
        data_acc = 1'b0;
        store    = 1'b0;
        idx      = 1'b0;
        illegal  = 1'b0;
        e_a      = 1'b0;
        e_b      = 1'b0;
        e_x      = 1'b0;
        e_pc     = 1'b0;
        e_cc     = 1'b0;
        rel      = 1'b0;
        alu_sel  = ALU_PASS;
        case (op)
            OP_NOP:      n_opd = 2'd0;
            OP_LDA_IMM:  begin n_opd = 2'd1; e_a = 1'b1; e_cc = 1'b1; end
            OP_LDB_IMM:  begin n_opd = 2'd1; e_b = 1'b1; e_cc = 1'b1; end
            OP_ADDA_IMM: begin n_opd = 2'd1; e_a = 1'b1; e_cc = 1'b1; alu_sel = ALU_ADD; end
            OP_SUBA_IMM: begin n_opd = 2'd1; e_a = 1'b1; e_cc = 1'b1; alu_sel = ALU_SUB; end
            OP_ANDA_IMM: begin n_opd = 2'd1; e_a = 1'b1; e_cc = 1'b1; alu_sel = ALU_AND; end
            OP_LDX_IMM:  begin n_opd = 2'd2; e_x = 1'b1; end
            OP_LDA_EXT: begin
                n_opd    = 2'd2;
                data_acc = 1'b1;
                e_a      = 1'b1;
                e_cc     = 1'b1;
            end
            OP_STA_EXT:  begin n_opd = 2'd2; data_acc = 1'b1; store = 1'b1; end
            OP_LDA_IDX: begin
                data_acc = 1'b1;
                idx      = 1'b1;
                e_a      = 1'b1;
                e_cc     = 1'b1;
            end
            OP_DECB:     begin e_b = 1'b1; e_cc = 1'b1; alu_sel = ALU_DEC; end
            OP_JMP_EXT:  begin n_opd = 2'd2; e_pc = 1'b1; end
            OP_BNE: begin
                n_opd = 2'd1;
                e_pc  = ~cc[CC_Z];   // Not taken skips the execute cycle
                rel   = 1'b1;
            end
            default:     illegal = 1'b1;
        endcase
    end

    assign has_exec = e_a | e_b | e_x | e_pc;

    always_comb begin
        nx_state = state;
        case (state)
            ST_FETCH: begin
                if (fetch) begin
                    if (illegal)              nx_state = ST_STOP;
                    else if (n_opd == 2'd2)   nx_state = ST_OPD_HI;
                    else if (n_opd == 2'd1)   nx_state = ST_OPD_LO;
                    else if (data_acc)        nx_state = ST_DATA;
                    else if (has_exec)        nx_state = ST_EXEC;
                end
            end
            ST_OPD_HI: nx_state = ST_OPD_LO;
            ST_OPD_LO: nx_state = data_acc ? ST_DATA : (has_exec ? ST_EXEC : ST_FETCH);
            ST_DATA:   nx_state = has_exec ? ST_EXEC : ST_FETCH;   // Stores end here
            ST_EXEC:   nx_state = ST_FETCH;
            default:   nx_state = ST_STOP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_FETCH;
            buserror <= 1'b0;
        end else begin
            if (step) state <= nx_state;
            if (state == ST_STOP) buserror <= 1'b1;
        end
    end

    // mdata holds the opcode address right after the fetch
    always_ff @(posedge clk) begin
        if (state == ST_STOP && !buserror) pcbad <= mdata;
    end

    assign fetch   = (state == ST_FETCH) & ~halt;   // Halt waits on a boundary
    assign opd     = (state == ST_OPD_HI) | (state == ST_OPD_LO);
    assign rd_x    = (state == ST_DATA) & idx;
    assign hi_addr = (state == ST_DATA) & ~idx;
    assign wrq     = (state == ST_DATA) & store;

    assign up_a   = (state == ST_EXEC) & e_a;
    assign up_b   = (state == ST_EXEC) & e_b;
    assign up_x   = (state == ST_EXEC) & e_x;
    assign up_pc  = (state == ST_EXEC) & e_pc;
    assign up_cc  = (state == ST_EXEC) & e_cc;
    assign pc_rel = (state == ST_EXEC) & rel;

endmodule

// ==== source/kcpu.sv ====
// Reduced 8-bit core top level, no interrupts and no stack
// The core steps on every second cycle where cen2 and dtack are both high
// cen_out and the internal enables are registered, so they lag cen2/dtack by one clk
// Only the low 16 address lines exist
`timescale 1ns/100ps

module kcpu import kcpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  cen2,
    output logic  cen_out,

    input  logic  halt,
    input  logic  dtack,

    // Memory bus
    input  byte_t din,
    output byte_t dout,
    output addr_t addr,
    output logic  we,
    output addr_t pcbad,
    output logic  buserror,

    // Register view
    output byte_t a,
    output byte_t b,
    output byte_t cc,
    output addr_t x,
    output addr_t pc,
    output logic  is_op
);

    opcode_t op;
    addr_t   mdata;
    byte_t   rslt, cc_out, opnd0, opnd1;
    alu_op_e alu_sel;
    logic    mem_busy, fetch, opd, rd_x, wrq, hi_addr;
    logic    up_a, up_b, up_x, up_pc, up_cc, pc_rel;
    logic    clken, clken2, phase;

    assign cen_out = clken2;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase  <= 1'b0;
            clken  <= 1'b0;
            clken2 <= 1'b0;
        end else begin
            if (cen2 && dtack) phase <= ~phase;
            clken  <= cen2 & dtack & phase;   // Half rate core enable
            clken2 <= cen2 & dtack;
        end
    end

    kcpu_ctrl u_ctrl (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cen      ( clken    ),
        .halt     ( halt     ),
        .mem_busy ( mem_busy ),
        .op       ( op       ),
        .mdata    ( mdata    ),
        .cc       ( cc       ),
        .fetch    ( fetch    ),
        .opd      ( opd      ),
        .rd_x     ( rd_x     ),
        .wrq      ( wrq      ),
        .hi_addr  ( hi_addr  ),
        .up_a     ( up_a     ),
        .up_b     ( up_b     ),
        .up_x     ( up_x     ),
        .up_pc    ( up_pc    ),
        .up_cc    ( up_cc    ),
        .pc_rel   ( pc_rel   ),
        .buserror ( buserror ),
        .alu_sel  ( alu_sel  ),
        .pcbad    ( pcbad    )
    );

    kcpu_memctrl u_memctrl (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cen      ( clken    ),
        .fetch    ( fetch    ),
        .opd      ( opd      ),
        .rd_x     ( rd_x     ),
        .wrq      ( wrq      ),
        .hi_addr  ( hi_addr  ),
        .pc       ( pc       ),
        .x        ( x        ),
        .din      ( din      ),
        .alu_dout ( a        ),   // STA only stores A
        .addr     ( addr     ),
        .dout     ( dout     ),
        .we       ( we       ),
        .is_op    ( is_op    ),
        .mem_busy ( mem_busy ),
        .op       ( op       ),
        .mdata    ( mdata    )
    );

    kcpu_alu u_alu (
        .opnd0    ( opnd0    ),
        .opnd1    ( opnd1    ),
        .cc_in    ( cc       ),
        .alu_sel  ( alu_sel  ),
        .rslt     ( rslt     ),
        .cc_out   ( cc_out   )
    );

    kcpu_regs u_regs (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cen      ( clken    ),
        .up_a     ( up_a     ),
        .up_b     ( up_b     ),
        .up_x     ( up_x     ),
        .up_pc    ( up_pc    ),
        .up_cc    ( up_cc    ),
        .pc_rel   ( pc_rel   ),
        .fetch    ( fetch    ),
        .opd      ( opd      ),
        .alu_sel  ( alu_sel  ),
        .mdata    ( mdata    ),
        .rslt     ( rslt     ),
        .alu_cc   ( cc_out   ),
        .a        ( a        ),
        .b        ( b        ),
        .cc       ( cc       ),
        .opnd0    ( opnd0    ),
        .opnd1    ( opnd1    ),
        .x        ( x        ),
        .pc       ( pc       )
    );

endmodule

// ==== source/kcpu_alu.sv ====
// Combinational 8-bit ALU
// N and Z always follow the result
// C is a borrow on subtract, as on the 6809
`timescale 1ns/100ps

module kcpu_alu import kcpu_pkg::*; (
    input  byte_t   opnd0,
    input  byte_t   opnd1,
    input  byte_t   cc_in,
    input  alu_op_e alu_sel,
    output byte_t   rslt,
    output byte_t   cc_out
);

    logic [8:0] sum;
    logic       c, v;

    always_comb begin
        sum = 9'd0;
        c   = cc_in[CC_C];
        v   = 1'b0;
        case (alu_sel)
            ALU_ADD: begin
                sum  = {1'b0, opnd0} + {1'b0, opnd1};
                rslt = sum[7:0];
                c    = sum[8];
                v    = (opnd0[7] == opnd1[7]) && (rslt[7] != opnd0[7]);
            end
            ALU_SUB: begin
                sum  = {1'b0, opnd0} - {1'b0, opnd1};
                rslt = sum[7:0];
                c    = sum[8];   // Borrow
                v    = (opnd0[7] != opnd1[7]) && (rslt[7] != opnd0[7]);
            end
            ALU_AND: rslt = opnd0 & opnd1;
            ALU_DEC: begin
                rslt = opnd0 - 8'd1;
                v    = (opnd0 == 8'h80);
            end
            default: rslt = opnd1;   // Loads
        endcase
    end

    always_comb begin
        cc_out       = cc_in;
        cc_out[CC_C] = c;
        cc_out[CC_V] = v;
        cc_out[CC_Z] = (rslt == 8'd0);
        cc_out[CC_N] = rslt[7];
    end

endmodule

// ==== source/kcpu_memctrl.sv ====
// Bus address select and read capture
// One access per core enable; din must be valid on that enable
// op shows din directly during a fetch so control can decode without a wait
`timescale 1ns/100ps

module kcpu_memctrl import kcpu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    cen,
    input  logic    fetch,
    input  logic    opd,
    input  logic    rd_x,
    input  logic    wrq,
    input  logic    hi_addr,
    input  addr_t   pc,
    input  addr_t   x,
    input  byte_t   din,
    input  byte_t   alu_dout,

    output addr_t   addr,
    output byte_t   dout,
    output logic    we,
    output logic    is_op,
    output logic    mem_busy,
    output opcode_t op,
    output addr_t   mdata
);

    opcode_t op_r;
    logic    rd_shift;

    always_comb begin
        if (rd_x)         addr = x;
        else if (hi_addr) addr = mdata;   // Extended operand address
        else              addr = pc;
    end

    assign we       = wrq;
    assign dout     = alu_dout;
    assign is_op    = fetch & cen;
    assign mem_busy = (fetch | opd | rd_x | hi_addr) & ~cen;
    assign op       = fetch ? din : op_r;
    assign rd_shift = opd | rd_x | (hi_addr & ~wrq);

    always_ff @(posedge clk) begin
        if (rst) begin
            op_r <= OP_NOP;
        end else if (cen && fetch) begin
            op_r <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            if (fetch)         mdata <= pc;                    // Kept for fault reporting
            else if (rd_shift) mdata <= {mdata[7:0], din};     // High byte arrives first
        end
    end

endmodule

// ==== source/kcpu_regs.sv ====
// Register file for A, B, X, PC and CC
// All updates happen on the core enable only
// BNE offsets are relative to the PC after the operand byte
`timescale 1ns/100ps

module kcpu_regs import kcpu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    cen,
    input  logic    up_a,
    input  logic    up_b,
    input  logic    up_x,
    input  logic    up_pc,
    input  logic    up_cc,
    input  logic    pc_rel,
    input  logic    fetch,
    input  logic    opd,
    input  alu_op_e alu_sel,
    input  addr_t   mdata,
    input  byte_t   rslt,
    input  byte_t   alu_cc,

    output byte_t   a,
    output byte_t   b,
    output byte_t   cc,
    output byte_t   opnd0,
    output byte_t   opnd1,
    output addr_t   x,
    output addr_t   pc
);

    addr_t rel_pc;

    assign rel_pc = pc + {{8{mdata[7]}}, mdata[7:0]};   // Sign-extended offset

    // ALU operand routing
    assign opnd0 = (alu_sel == ALU_DEC) ? b : a;
    assign opnd1 = mdata[7:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            a  <= 8'd0;
            b  <= 8'd0;
            cc <= 8'd0;
            x  <= 16'd0;
            pc <= RESET_PC;
        end else if (cen) begin
            if (up_a)  a  <= rslt;
            if (up_b)  b  <= rslt;
            if (up_cc) cc <= alu_cc;
            if (up_x)  x  <= mdata;
            if (up_pc) begin
                pc <= pc_rel ? rel_pc : mdata;
            end else if (fetch || opd) begin
                pc <= pc + 16'd1;   // Past each opcode or operand byte
            end
        end
    end

endmodule

// ==== tests/kcpu_mem.sv ====
// 64 KB byte memory model for the core testbench
// Reads are combinational from addr, writes land on every clock with we high
// dtack drops at random while stall is set, otherwise it stays high
// Contents are loaded by the testbench through the mem array
`timescale 1ns/100ps

module kcpu_mem (
    input  logic        clk,
    input  logic        stall,
    input  logic [15:0] addr,
    input  logic        we,
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata,
    output logic        dtack
);

    logic [7:0] mem [0:65535];

    assign rdata = mem[addr];

    initial begin
        dtack = 1'b1;
    end

    // Random wait states, roughly one in three cycles
    always @(posedge clk) begin
        if (stall) begin
            dtack <= ($urandom % 3) != 0;
        end else begin
            dtack <= 1'b1;
        end
    end

    // Store data is held for the whole access, so repeated writes are harmless
    always @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

endmodule

// ==== tests/kcpu_tb.sv ====
// Testbench for the reduced 8-bit core
// Each table entry resets the core, loads a program and runs to a store at 8000h
// Illegal opcode entries run to buserror instead
// cen_out is registered, so it is checked against cen2 and dtack of the previous clk
`timescale 1ns/100ps

module kcpu_tb import kcpu_pkg::*; ();

    localparam logic [2:0] K_PASS = 3'd0, K_ADD = 3'd1, K_SUB = 3'd2, K_AND = 3'd3;
    localparam logic [2:0] K_DEC = 3'd4, SEL_LOOP = 3'd5, SEL_IDX = 3'd6, SEL_ILL = 3'd7;
    localparam logic [1:0] M_NONE = 2'd0, M_STALL = 2'd1, M_HALT = 2'd2;
    localparam int NUM_ENTRIES = 14;
    localparam int LIMIT = NUM_ENTRIES * 40 * 6 * 4;

    // Operand pair, op selector, loop count or data byte, stall mode
    typedef struct packed {
        logic [7:0] p;
        logic [7:0] q;
        logic [2:0] sel;
        logic [7:0] cnt;
        logic [1:0] mode;
    } entry_t;

    logic   clk, rst, cen2, halt, dtack, stall_on, prev_ok;
    logic   cen_out, we, is_op, buserror;
    byte_t  din, dout, a, b, cc;
    addr_t  addr, pcbad, x, pc;
    entry_t tbl [0:NUM_ENTRIES-1];
    int     errors, cycles, seed_val;

    kcpu dut_i (
        .clk(clk), .rst(rst), .cen2(cen2), .cen_out(cen_out), .halt(halt), .dtack(dtack),
        .din(din), .dout(dout), .addr(addr), .we(we), .pcbad(pcbad), .buserror(buserror),
        .a(a), .b(b), .cc(cc), .x(x), .pc(pc), .is_op(is_op)
    );

    kcpu_mem mem_i (
        .clk(clk), .stall(stall_on), .addr(addr), .we(we), .wdata(dout),
        .rdata(din), .dtack(dtack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Random gaps on cen2 in stall mode
    always @(posedge clk) begin
        cen2    <= stall_on ? (($urandom % 4) != 0) : 1'b1;
        prev_ok <= cen2 & dtack;
        cycles  <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles, the core never finished a program", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (!rst && cen_out && !prev_ok) begin
            $display("cen_out high at %0t although cen2 or dtack was low", $time);
            errors = errors + 1;
        end
    end

    // Returns {flags, result}, written from the instruction rules
    function automatic logic [15:0] ref_alu(input logic [2:0] kind, input logic [7:0] x_in,
                                            input logic [7:0] y_in, input logic [7:0] flags);
        int         sx, sy, ux, uy, s;
        logic [7:0] r, f;
        sx = $signed(x_in);
        sy = $signed(y_in);
        ux = x_in;
        uy = y_in;
        f  = flags;
        r  = y_in;
        f[CC_V] = 1'b0;
        case (kind)
            K_ADD: begin
                r = x_in + y_in;
                s = sx + sy;
                f[CC_V] = (s > 127) || (s < -128);
                f[CC_C] = (ux + uy) > 255;
            end
            K_SUB: begin
                r = x_in - y_in;
                s = sx - sy;
                f[CC_V] = (s > 127) || (s < -128);
                f[CC_C] = ux < uy;   // Borrow
            end
            K_AND: r = x_in & y_in;
            K_DEC: begin
                r = x_in - 8'd1;
                f[CC_V] = (x_in == 8'h80);
            end
            default: r = y_in;
        endcase
        f[CC_Z] = (r == 8'd0);
        f[CC_N] = r[7];
        return {f, r};
    endfunction

    task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic load_program(input entry_t e);
        logic [15:0] i;
        logic [7:0]  prog [0:12];
        for (int k = 0; k < 65536; k++) begin
            i = k;
            mem_i.mem[k] = i[15:8] ^ i[7:0] ^ 8'ha5;
        end
        case (e.sel)
            SEL_LOOP: prog = '{OP_LDB_IMM, e.cnt, OP_ADDA_IMM, e.q, OP_DECB, OP_BNE, 8'hfb,
                               OP_STA_EXT, 8'h80, 8'h00, 8'h00, 8'h00, 8'h00};
            SEL_IDX:  prog = '{OP_LDX_IMM, e.p, e.q, OP_LDA_IDX, OP_JMP_EXT, 8'h00, 8'h0a,
                               8'h01, 8'h01, 8'h01, OP_STA_EXT, 8'h80, 8'h00};
            SEL_ILL:  prog = '{OP_LDA_IMM, e.p, 8'h01, 8'h00, 8'h00, 8'h00, 8'h00,
                               8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
            default:  prog = '{OP_LDA_IMM, e.p,
                               (e.sel == K_ADD) ? OP_ADDA_IMM :
                               (e.sel == K_SUB) ? OP_SUBA_IMM : OP_ANDA_IMM,
                               e.q, OP_STA_EXT, 8'h80, 8'h00, 8'h00, 8'h00, 8'h00,
                               8'h00, 8'h00, 8'h00};
        endcase
        for (int k = 0; k < 13; k++) mem_i.mem[k] = prog[k];
        if (e.sel == SEL_IDX) mem_i.mem[{e.p, e.q}] = e.cnt;
    endtask

    task automatic run_entry(input int n, input entry_t e);
        logic [15:0] r;
        logic [7:0]  ea, eb, ecc, stored;
        addr_t       ex, epc;
        int          ops;
        ea = 8'd0;
        eb = 8'd0;
        ecc = 8'd0;
        ex = 16'd0;
        epc = 16'd0;
        stored = 8'd0;
        ops = 0;
        // Expected registers from the instruction sequence
        case (e.sel)
            SEL_LOOP: begin
                r = ref_alu(K_PASS, eb, e.cnt, ecc);
                {ecc, eb} = r;
                for (int k = 0; k < e.cnt; k++) begin
                    {ecc, ea} = ref_alu(K_ADD, ea, e.q, ecc);
                    {ecc, eb} = ref_alu(K_DEC, eb, 8'd0, ecc);
                end
                epc = 16'd10;   // Past the STA at 7
            end
            SEL_IDX: begin
                ex = {e.p, e.q};
                {ecc, ea} = ref_alu(K_PASS, ea, e.cnt, ecc);
                epc = 16'd13;   // Past the STA at 10
            end
            SEL_ILL: begin
                {ecc, ea} = ref_alu(K_PASS, ea, e.p, ecc);
                epc = 16'd3;    // Just past the bad opcode
            end
            default: begin
                {ecc, ea} = ref_alu(K_PASS, ea, e.p, ecc);
                {ecc, ea} = ref_alu(e.sel, ea, e.q, ecc);
                epc = 16'd7;    // Past the STA at 4
            end
        endcase
        @(posedge clk);
        rst      <= 1'b1;
        halt     <= 1'b0;
        stall_on <= (e.mode == M_STALL);
        load_program(e);
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_val("pc", pc, RESET_PC);
        if (we || is_op || buserror) begin
            $display("Entry %0d has we, is_op or buserror high during reset", n);
            errors = errors + 1;
        end
        @(posedge clk);
        rst <= 1'b0;
        if (e.mode == M_HALT) begin
            do @(negedge clk); while (!is_op);
            @(posedge clk);
            halt <= 1'b1;
            repeat (40) begin
                @(negedge clk);
                if (is_op) ops++;
            end
            if (ops != 0) begin
                $display("Entry %0d fetched %0d opcodes while halt was held", n, ops);
                errors = errors + 1;
            end
            @(posedge clk);
            halt <= 1'b0;
        end
        forever begin
            @(negedge clk);
            if (we && addr !== 16'h8000) begin
                $display("Entry %0d wrote to %h instead of 8000", n, addr);
                errors = errors + 1;
            end
            if (buserror || (we && addr === 16'h8000)) break;
        end
        stored = dout;
        if (e.sel == SEL_ILL) begin
            check_val("buserror", buserror, 1'b1);
            check_val("pcbad", pcbad, 16'h0002);
            repeat (50) begin
                @(negedge clk);
                if (we) begin
                    $display("Entry %0d wrote to memory after the illegal opcode", n);
                    errors = errors + 1;
                end
            end
        end else begin
            check_val("buserror", buserror, 1'b0);
            check_val("stored", stored, ea);
        end
        check_val("a", a, ea);
        check_val("b", b, eb);
        check_val("cc", cc, ecc);
        check_val("x", x, ex);
        check_val("pc", pc, epc);
    endtask

    initial begin
        rst      = 1'b1;
        cen2     = 1'b0;
        halt     = 1'b0;
        stall_on = 1'b0;
        prev_ok  = 1'b0;
        errors   = 0;
        cycles   = 0;
        seed_val = $urandom(32'h447d_73bc);
        tbl[0]  = {8'h12, 8'h34, K_ADD,    8'd0,  M_NONE};
        tbl[1]  = {8'h7f, 8'h01, K_ADD,    8'd0,  M_NONE};   // Signed overflow
        tbl[2]  = {8'h10, 8'h20, K_SUB,    8'd0,  M_NONE};   // Borrow
        tbl[3]  = {8'hf0, 8'h3c, K_AND,    8'd0,  M_STALL};
        tbl[4]  = {8'hff, 8'h01, K_ADD,    8'd0,  M_STALL};  // Carry and zero
        tbl[5]  = {8'h00, 8'h03, SEL_LOOP, 8'd5,  M_NONE};
        tbl[6]  = {8'h00, 8'h25, SEL_LOOP, 8'd10, M_STALL};
        tbl[7]  = {8'h12, 8'h34, SEL_IDX,  8'ha5, M_NONE};
        tbl[8]  = {8'h43, 8'h21, SEL_IDX,  8'h00, M_STALL};
        tbl[9]  = {8'h80, 8'h01, K_SUB,    8'd0,  M_HALT};
        tbl[10] = {8'h00, 8'h11, SEL_LOOP, 8'd4,  M_HALT};
        tbl[11] = {8'h55, 8'h00, SEL_ILL,  8'd0,  M_NONE};
        tbl[12] = {8'h80, 8'h00, SEL_ILL,  8'd0,  M_STALL};
        tbl[13] = {8'h0f, 8'h0f, SEL_IDX,  8'h80, M_HALT};
        for (int n = 0; n < NUM_ENTRIES; n++) run_entry(n, tbl[n]);
        $display("%0d errors over %0d entries", errors, NUM_ENTRIES);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
